/* frame_buf.f */
+incdir+.
frame_buf_pkg.sv
frame_len_check.sv
frame_fifo.sv
frame_stats.sv
frame_buf_top.sv
frame_buf_sva.sv
frame_buf_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := frame_buf_tb
FILELIST  := frame_buf.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* frame_buf_tb.sv */
`timescale 1ns/10ps

`include "frame_buf_macros.svh"

module frame_buf_tb;

    import frame_buf_pkg::*;

    localparam int N_FRAMES  = 200;
    localparam int LEN_RANGE = 40;
    localparam int DEPTH     = 1 << `FRAME_ADDR_WIDTH;
    // every beat of every frame at 8 cycles of 4 ns
    localparam int TIMEOUT_NS = N_FRAMES * LEN_RANGE * 8 * 4;

    logic  clk;
    logic  rst;
    data_t in_data;
    logic  in_valid;
    logic  in_ready;
    logic  in_last;
    logic  in_err;
    data_t out_data;
    logic  out_valid;
    logic  out_ready;
    logic  out_last;
    cnt_t  good_count;
    cnt_t  bad_count;
    cnt_t  overflow_count;

    // expected output beats, {last, data}
    logic [`FRAME_DATA_WIDTH:0] exp_q[$];
    int exp_good;
    int exp_bad;
    int exp_ovf;
    int data_errs;
    int count_errs;
    int other_errs;
    // one generator per stream side
    logic [31:0] in_rng;
    logic [31:0] out_rng;
    logic        slow_phase;

    frame_buf_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .in_data        (in_data),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_last        (in_last),
        .in_err         (in_err),
        .out_data       (out_data),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_last       (out_last),
        .good_count     (good_count),
        .bad_count      (bad_count),
        .overflow_count (overflow_count)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic bit values_match(input string name, input logic [31:0] exp,
                                        input logic [31:0] act);
        assert (act == exp) else begin
            $display("ERROR: %s expected %0h actual %0h", name, exp, act);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // hold the beat until in_ready was seen high before a rising edge
    task automatic send_beat(input data_t d, input logic last, input logic err);
        logic taken;
        in_data  = d;
        in_last  = last;
        in_err   = err;
        in_valid = 1'b1;
        taken    = 1'b0;
        // in_ready follows only registers, settled by the falling edge
        while (!taken) begin
            taken = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic send_frame();
        int        n;
        int        err_beat;
        beat_len_t len;
        data_t     payload[$];
        in_rng = xorshift32(in_rng);
        n      = int'(in_rng % LEN_RANGE) + 1;
        len    = beat_len_t'(n);
        in_rng = xorshift32(in_rng);
        // source error on about one frame in sixteen
        err_beat = (in_rng[7:4] == 4'h0) ? int'(in_rng >> 8) % n : -1;
        for (int i = 0; i < n; i++) begin
            in_rng = xorshift32(in_rng);
            payload.push_back(data_t'(in_rng >> 16));
        end
        // fate of the frame
        if (n > DEPTH) begin
            exp_ovf++;
        end else if (len < beat_len_t'(`FRAME_MIN_LEN) || len > beat_len_t'(`FRAME_MAX_LEN)
                     || err_beat >= 0) begin
            exp_bad++;
        end else begin
            exp_good++;
            for (int i = 0; i < n; i++) begin
                exp_q.push_back({1'(i == n - 1), payload[i]});
            end
        end
        for (int i = 0; i < n; i++) begin
            in_rng = xorshift32(in_rng);
            // random idle gaps between beats
            while (in_rng[2:0] == 3'd0) begin
                @(negedge clk);
                in_rng = xorshift32(in_rng);
            end
            send_beat(payload[i], 1'(i == n - 1), 1'(i == err_beat));
        end
    endtask

    // output side, ready drawn and beat checked at the falling edge
    always @(negedge clk) begin
        logic [`FRAME_DATA_WIDTH:0] exp_beat;
        if (!rst) begin
            out_rng = xorshift32(out_rng);
            // rare toggles into long slow phases so the fifo fills
            if (out_rng[7:0] < 8'd8) begin
                slow_phase = !slow_phase;
            end
            out_ready = slow_phase ? (out_rng[11:8] == 4'h0) : (out_rng[9:8] != 2'b00);
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0) else begin
                    other_errs++;
                    $display("output beat appeared with no good frame pending");
                end
                if (exp_q.size() != 0) begin
                    exp_beat = exp_q.pop_front();
                    if (!values_match("output_beat", 32'(exp_beat),
                                      32'({out_last, out_data}))) begin
                        data_errs++;
                    end
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        in_data    = '0;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        in_err     = 1'b0;
        out_ready  = 1'b0;
        slow_phase = 1'b0;
        in_rng     = 32'hd65;
        out_rng    = ~32'hd65;
        exp_good   = 0;
        exp_bad    = 0;
        exp_ovf    = 0;
        data_errs  = 0;
        count_errs = 0;
        other_errs = 0;
        repeat (10) @(negedge clk);
        // every process at this edge still sees reset high
        rst <= 1'b0;
        @(negedge clk);
        // idle state straight after reset
        if (!values_match("reset_good_count", 0, 32'(good_count))) count_errs++;
        if (!values_match("reset_bad_count", 0, 32'(bad_count))) count_errs++;
        if (!values_match("reset_overflow_count", 0, 32'(overflow_count))) count_errs++;
        if (!values_match("reset_out_valid", 0, 32'(out_valid))) other_errs++;
        if (!values_match("reset_in_ready", 1, 32'(in_ready))) other_errs++;
        for (int f = 0; f < N_FRAMES; f++) begin
            send_frame();
        end
        // drain every stored good frame
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // counts trail the last accepted beat by two cycles
        repeat (8) @(negedge clk);
        if (!values_match("idle_out_valid", 0, 32'(out_valid))) other_errs++;
        if (!values_match("good_count", 32'(exp_good), 32'(good_count))) count_errs++;
        if (!values_match("bad_count", 32'(exp_bad), 32'(bad_count))) count_errs++;
        if (!values_match("overflow_count", 32'(exp_ovf), 32'(overflow_count))) count_errs++;
        $display("errors: data %0d, count %0d, other %0d", data_errs, count_errs, other_errs);
        if (data_errs + count_errs + other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* frame_buf_sva.sv */
`timescale 1ns/10ps

module frame_buf_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 chk_valid,
    input logic                 chk_ready,
    input logic                 chk_last,
    input frame_buf_pkg::data_t out_data,
    input logic                 out_valid,
    input logic                 out_ready,
    input logic                 out_last,
    input logic                 good_frame,
    input logic                 bad_frame,
    input logic                 overflow,
    input logic                 fifo_empty
);

    // stalled beat keeps its payload
    out_stable_a: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("output beat changed while stalled");

    // at most one fate per cycle
    pulse_excl_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0({good_frame, bad_frame, overflow}))
        else $error("more than one status pulse at once");

    // each pulse follows exactly one accepted last beat
    pulse_once_a: assert property (@(posedge clk) disable iff (rst)
        (good_frame || bad_frame || overflow) |-> $past(chk_valid && chk_ready && chk_last))
        else $error("status pulse without an accepted last beat");

    reset_out_a: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high after reset");

    // empty fifo always takes input
    empty_ready_a: assert property (@(posedge clk) disable iff (rst)
        fifo_empty |-> chk_ready)
        else $error("chk_ready low while the fifo is empty");

endmodule

bind frame_fifo frame_buf_sva sva_i (
    .clk        (clk),
    .rst        (rst),
    .chk_valid  (chk_valid),
    .chk_ready  (chk_ready),
    .chk_last   (chk_last),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_last   (out_last),
    .good_frame (good_frame),
    .bad_frame  (bad_frame),
    .overflow   (overflow),
    .fifo_empty (empty)
);

/* frame_buf_top.sv */
`timescale 1ns/10ps

module frame_buf_top (
    input  logic                 clk,
    input  logic                 rst,
    input  frame_buf_pkg::data_t in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic                 in_last,
    input  logic                 in_err,
    output frame_buf_pkg::data_t out_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 out_last,
    output frame_buf_pkg::cnt_t  good_count,
    output frame_buf_pkg::cnt_t  bad_count,
    output frame_buf_pkg::cnt_t  overflow_count
);

    import frame_buf_pkg::*;

    // checker to fifo
    data_t chk_data;
    logic  chk_valid;
    logic  chk_ready;
    logic  chk_last;
    logic  chk_bad;

    // fifo status pulses
    logic  good_frame;
    logic  bad_frame;
    logic  overflow;

    frame_len_check len_check_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .in_err    (in_err),
        .chk_data  (chk_data),
        .chk_valid (chk_valid),
        .chk_ready (chk_ready),
        .chk_last  (chk_last),
        .chk_bad   (chk_bad)
    );

    frame_fifo fifo_i (
        .clk        (clk),
        .rst        (rst),
        .chk_data   (chk_data),
        .chk_valid  (chk_valid),
        .chk_ready  (chk_ready),
        .chk_last   (chk_last),
        .chk_bad    (chk_bad),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_last   (out_last),
        .good_frame (good_frame),
        .bad_frame  (bad_frame),
        .overflow   (overflow)
    );

    frame_stats stats_i (
        .clk            (clk),
        .rst            (rst),
        .good_frame     (good_frame),
        .bad_frame      (bad_frame),
        .overflow       (overflow),
        .good_count     (good_count),
        .bad_count      (bad_count),
        .overflow_count (overflow_count)
    );

endmodule

/* frame_stats.sv */
`timescale 1ns/10ps

module frame_stats (
    input  logic                clk,
    input  logic                rst,
    input  logic                good_frame,
    input  logic                bad_frame,
    input  logic                overflow,
    output frame_buf_pkg::cnt_t good_count,
    output frame_buf_pkg::cnt_t bad_count,
    output frame_buf_pkg::cnt_t overflow_count
);

    import frame_buf_pkg::*;

    // next count, sticks at all ones
    function automatic cnt_t sat_inc(input cnt_t cnt);
        return (cnt == '1) ? cnt : cnt + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            good_count     <= '0;
            bad_count      <= '0;
            overflow_count <= '0;
        end else begin
            // pulses are exclusive, but each counter stands alone
            if (good_frame) begin
                good_count <= sat_inc(good_count);
            end
            if (bad_frame) begin
                bad_count <= sat_inc(bad_count);
            end
            if (overflow) begin
                overflow_count <= sat_inc(overflow_count);
            end
        end
    end

endmodule

/* frame_fifo.sv */
`timescale 1ns/10ps

`include "frame_buf_macros.svh"

module frame_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  frame_buf_pkg::data_t chk_data,
    input  logic                 chk_valid,
    output logic                 chk_ready,
    input  logic                 chk_last,
    input  logic                 chk_bad,
    output frame_buf_pkg::data_t out_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 out_last,
    output logic                 good_frame,
    output logic                 bad_frame,
    output logic                 overflow
);

    localparam int ADDR_W = `FRAME_ADDR_WIDTH;
    localparam int DATA_W = `FRAME_DATA_WIDTH;
    localparam int DEPTH  = 1 << ADDR_W;

    // pointers carry one extra wrap bit
    // committed end of stored good frames
    logic [ADDR_W:0] wr_ptr;
    // write position of the frame in progress
    logic [ADDR_W:0] wr_ptr_cur;
    // registered read address, addresses the memory
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] wr_ptr_next;
    logic [ADDR_W:0] wr_ptr_cur_next;
    logic [ADDR_W:0] rd_ptr_next;

    // {last, data} per entry
    logic [DATA_W:0] mem [DEPTH];
    logic [DATA_W:0] mem_rd_q;
    logic            mem_rd_valid;
    logic [DATA_W:0] out_q;
    logic            out_valid_q;

    logic            full;
    logic            full_cur;
    logic            empty;
    logic            write;
    logic            read;
    logic            advance;
    logic            good_next;
    logic            bad_next;
    logic            overflow_next;

    // frame in progress is a whole depth past the reader
    assign full = (wr_ptr_cur[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr_cur[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    // current frame alone has filled the memory
    assign full_cur = (wr_ptr_cur[ADDR_W] != wr_ptr[ADDR_W]) &&
                      (wr_ptr_cur[ADDR_W-1:0] == wr_ptr[ADDR_W-1:0]);
    // nothing committed left to read
    assign empty = (wr_ptr == rd_ptr);

    // oversized frame keeps draining so it can be dropped
    // otherwise back-pressure while full
    assign chk_ready = !full || full_cur;

    always_comb begin
        write           = 1'b0;
        wr_ptr_next     = wr_ptr;
        wr_ptr_cur_next = wr_ptr_cur;
        good_next       = 1'b0;
        bad_next        = 1'b0;
        overflow_next   = 1'b0;
        if (chk_valid && chk_ready) begin
            if (full_cur) begin
                // discard beats up to the end of the frame
                if (chk_last) begin
                    wr_ptr_cur_next = wr_ptr;
                    overflow_next   = 1'b1;
                end
            end else begin
                write           = 1'b1;
                wr_ptr_cur_next = wr_ptr_cur + 1'b1;
                if (chk_last) begin
                    if (chk_bad) begin
                        // roll back to the last commit
                        wr_ptr_cur_next = wr_ptr;
                        bad_next        = 1'b1;
                    end else begin
                        // commit, frame becomes readable
                        wr_ptr_next = wr_ptr_cur + 1'b1;
                        good_next   = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            wr_ptr_cur <= '0;
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            wr_ptr     <= wr_ptr_next;
            wr_ptr_cur <= wr_ptr_cur_next;
            // one-cycle status, after the last beat
            good_frame <= good_next;
            bad_frame  <= bad_next;
            overflow   <= overflow_next;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr_cur[ADDR_W-1:0]] <= {chk_last, chk_data};
        end
    end

    // pipeline moves when output is taken or empty
    assign advance = out_ready || !out_valid_q;

    always_comb begin
        read        = 1'b0;
        rd_ptr_next = rd_ptr;
        if (advance && !empty) begin
            read        = 1'b1;
            rd_ptr_next = rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr       <= '0;
            mem_rd_valid <= 1'b0;
            out_valid_q  <= 1'b0;
        end else begin
            rd_ptr <= rd_ptr_next;
            if (advance) begin
                mem_rd_valid <= !empty;
                out_valid_q  <= mem_rd_valid;
            end
        end
    end

    // read register, then output register
    always_ff @(posedge clk) begin
        if (read) begin
            mem_rd_q <= mem[rd_ptr[ADDR_W-1:0]];
        end
        if (advance) begin
            out_q <= mem_rd_q;
        end
    end

    assign out_valid          = out_valid_q;
    assign {out_last, out_data} = out_q;

endmodule

/* frame_len_check.sv */
`timescale 1ns/10ps

`include "frame_buf_macros.svh"

module frame_len_check (
    input  logic                 clk,
    input  logic                 rst,
    input  frame_buf_pkg::data_t in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic                 in_last,
    input  logic                 in_err,
    output frame_buf_pkg::data_t chk_data,
    output logic                 chk_valid,
    input  logic                 chk_ready,
    output logic                 chk_last,
    output logic                 chk_bad
);

    import frame_buf_pkg::*;

    // beats already accepted in the current frame
    beat_len_t beat_cnt;
    // length counting the beat presented now
    beat_len_t frame_len;
    // in_err seen on an earlier beat
    logic      err_seen;
    logic      xfer;
    logic      len_bad;

    // stream passes straight through, no added latency
    assign chk_data  = in_data;
    assign chk_valid = in_valid;
    assign chk_last  = in_last;
    assign in_ready  = chk_ready;

    assign xfer = in_valid && in_ready;

    // hold at max so a runaway frame still reads as too long
    assign frame_len = (beat_cnt == '1) ? beat_cnt : beat_cnt + 1'b1;

    assign len_bad = (frame_len < beat_len_t'(`FRAME_MIN_LEN)) ||
                     (frame_len > beat_len_t'(`FRAME_MAX_LEN));

    // verdict only on the last beat
    assign chk_bad = in_last && (err_seen || in_err || len_bad);

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
            err_seen <= 1'b0;
        end else if (xfer) begin
            if (in_last) begin
                // frame done, start fresh
                beat_cnt <= '0;
                err_seen <= 1'b0;
            end else begin
                beat_cnt <= frame_len;
                err_seen <= err_seen || in_err;
            end
        end
    end

endmodule

/* frame_buf_pkg.sv */
`include "frame_buf_macros.svh"

package frame_buf_pkg;

    // one beat of stream payload
    typedef logic [`FRAME_DATA_WIDTH-1:0] data_t;

    // frame length in beats
    // 7 bits, so a count can sit above the fifo depth before it saturates
    typedef logic [6:0] beat_len_t;

    // one statistics count
    typedef logic [`FRAME_CNT_WIDTH-1:0] cnt_t;

endpackage

/* frame_buf_macros.svh */
`ifndef FRAME_BUF_MACROS_SVH
`define FRAME_BUF_MACROS_SVH

// payload bits per beat
`define FRAME_DATA_WIDTH 8
// fifo holds 2**FRAME_ADDR_WIDTH beats
`define FRAME_ADDR_WIDTH 5
// window of good frame lengths, in beats
`define FRAME_MIN_LEN 4
`define FRAME_MAX_LEN 24
// width of each statistics counter
`define FRAME_CNT_WIDTH 16

`endif
